// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// word address, one 64-bit word per address
`define DC_ADDR_BITS 12

// direct-mapped, 16 lines of one word each
`define DC_INDEX_BITS 4
`define DC_LINES (1 << `DC_INDEX_BITS)
`define DC_TAG_BITS (`DC_ADDR_BITS - `DC_INDEX_BITS)

`define DC_WORD_BITS 64

// request id width
`define DC_ID_BITS 3

// outstanding misses and write-backs
`define DC_MSHR_DEPTH 4

`endif

// File: logic/dcache_controller.sv
`default_nettype none

module dcache_controller import dcache_types_pkg::*, mem_bus_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,

    // held request
    input  dc_req_t     cur,
    input  logic        cur_valid,
    output logic        cur_take,

    // array
    output dc_addr_t    rd_addr,
    input  logic        rd_hit,
    input  dc_word_t    rd_data,
    output dc_wr_t      wr,
    output logic        wr_en,
    input  logic        evict_valid,
    input  logic        evict_dirty,
    input  dc_addr_t    evict_addr,
    input  dc_word_t    evict_data,

    // MSHR
    output dc_addr_t    search_addr,
    input  logic        search_hit,
    output mshr_alloc_t alloc,
    output logic        alloc_valid,
    input  logic        alloc_ready,
    input  fill_t       fill,
    input  logic        fill_valid,
    output logic        fill_take,

    // processor response
    output dc_rsp_t     rsp,
    output logic        rsp_valid
);

    logic is_store;
    logic store_hit;
    logic need_evict;
    logic evict_go;
    logic fill_rsp;
    logic load_hit_go;
    logic miss_go;

    assign rd_addr     = cur.addr;
    assign search_addr = cur.addr;
    assign is_store    = (cur.op == DC_STORE);

    // store hit owns the write port
    assign store_hit = cur_valid && is_store && rd_hit;

    always_comb begin
        if (store_hit) begin
            wr = '{addr: cur.addr, data: cur.data, dirty: 1'b1};
        end else begin
            wr = '{addr: fill.addr, data: fill.data, dirty: fill.dirty};
        end
    end

    // a different dirty word at the fill index must be written back
    assign need_evict = evict_valid && evict_dirty && (evict_addr != fill.addr);
    assign fill_take  = fill_valid && !store_hit && (!need_evict || alloc_ready);
    assign evict_go   = fill_take && need_evict;
    assign wr_en      = store_hit || fill_take;

    // one response register, the fill goes first
    assign fill_rsp    = fill_take && (fill.kind == MSHR_LOAD);
    assign load_hit_go = cur_valid && !is_store && rd_hit && !fill_rsp;

    // miss waits on a matching entry or on the evict allocation
    assign miss_go  = cur_valid && !rd_hit && !search_hit && alloc_ready && !evict_go;
    assign cur_take = load_hit_go || store_hit || miss_go;

    assign alloc_valid = evict_go || miss_go;

    always_comb begin
        if (evict_go) begin
            alloc = '{kind: MSHR_EVICT, addr: evict_addr, data: evict_data, id: '0};
        end else begin
            alloc.kind = is_store ? MSHR_STORE : MSHR_LOAD;
            alloc.addr = cur.addr;
            alloc.data = cur.data;
            alloc.id   = cur.id;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= fill_rsp || load_hit_go;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_rsp) begin
            rsp <= '{id: fill.id, data: fill.data};
        end else if (load_hit_go) begin
            rsp <= '{id: cur.id, data: rd_data};
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache_mem.sv
`default_nettype none

`include "dcache_consts.svh"

module dcache_mem import dcache_types_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,

    // lookup
    input  dc_addr_t rd_addr,
    output logic     rd_hit,
    output dc_word_t rd_data,

    // single write port
    input  dc_wr_t   wr,
    input  logic     wr_en,

    // occupant of the write index
    output logic     evict_valid,
    output logic     evict_dirty,
    output dc_addr_t evict_addr,
    output dc_word_t evict_data
);

    localparam int LINES = `DC_LINES;

    logic [`DC_TAG_BITS-1:0]   tags  [LINES];
    dc_word_t                  words [LINES];
    logic [LINES-1:0]          valid_q;
    logic [LINES-1:0]          dirty_q;

    logic [`DC_INDEX_BITS-1:0] rd_idx;
    logic [`DC_INDEX_BITS-1:0] wr_idx;

    assign rd_idx = rd_addr[`DC_INDEX_BITS-1:0];
    assign wr_idx = wr.addr[`DC_INDEX_BITS-1:0];

    assign rd_hit  = valid_q[rd_idx] && (tags[rd_idx] == rd_addr[`DC_ADDR_BITS-1:`DC_INDEX_BITS]);
    assign rd_data = words[rd_idx];

    // victim as seen before the write lands
    assign evict_valid = valid_q[wr_idx];
    assign evict_dirty = dirty_q[wr_idx];
    assign evict_addr  = {tags[wr_idx], wr_idx};
    assign evict_data  = words[wr_idx];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
            dirty_q[wr_idx] <= wr.dirty;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            tags[wr_idx]  <= wr.addr[`DC_ADDR_BITS-1:`DC_INDEX_BITS];
            words[wr_idx] <= wr.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache_mshr.sv
`default_nettype none

`include "dcache_consts.svh"

module dcache_mshr import dcache_types_pkg::*, mem_bus_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,
    input  mshr_alloc_t alloc,
    input  logic        alloc_valid,
    output logic        alloc_ready,
    input  dc_addr_t    search_addr,
    output logic        search_hit,
    output fill_t       fill,
    output logic        fill_valid,
    input  logic        fill_take,
    output mem_req_t    mem_req,
    output logic        mem_req_valid,
    input  logic        mem_req_ready,
    input  mem_rsp_t    mem_rsp,
    input  logic        mem_rsp_valid
);

    localparam int DEPTH = `DC_MSHR_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    mshr_state_e      state [DEPTH];
    mshr_kind_e       kind  [DEPTH];
    dc_addr_t         addr  [DEPTH];
    dc_word_t         data  [DEPTH];
    dc_id_t           id    [DEPTH];

    // entries waiting to issue, in allocation order
    logic [PTR_W-1:0] iq [DEPTH];
    logic [PTR_W-1:0] iq_head;
    logic [PTR_W-1:0] iq_tail;
    logic [PTR_W:0]   iq_count;

    // issued loads in bus order, read by rsp and fill pointers
    logic [PTR_W-1:0] lq [DEPTH];
    logic [PTR_W-1:0] lq_push;
    logic [PTR_W-1:0] lq_rsp;
    logic [PTR_W-1:0] lq_fill;

    logic [PTR_W-1:0] free_idx;
    logic [PTR_W-1:0] slot;
    logic [PTR_W-1:0] issue_idx;
    logic [PTR_W-1:0] rsp_idx;
    logic [PTR_W-1:0] fill_idx;
    logic             free_any;
    logic             issue_fire;
    logic             issue_load;

    // lowest free entry and address match
    always_comb begin
        free_any   = 1'b0;
        free_idx   = '0;
        search_hit = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (state[i] == MS_IDLE) begin
                free_any = 1'b1;
                free_idx = PTR_W'(i);
            end else if (addr[i] == search_addr) begin
                search_hit = 1'b1;
            end
        end
    end

    assign fill_idx   = lq[lq_fill];
    assign fill_valid = (state[fill_idx] == MS_FILL);

    // the presented fill's entry is recycled when it is taken
    assign alloc_ready = free_any || fill_valid;
    assign slot        = free_any ? free_idx : fill_idx;

    assign issue_idx     = iq[iq_head];
    assign mem_req_valid = (iq_count != '0);
    assign issue_fire    = mem_req_valid && mem_req_ready;
    assign issue_load    = (kind[issue_idx] != MSHR_EVICT);
    assign rsp_idx       = lq[lq_rsp];

    assign mem_req.cmd  = issue_load ? BUS_LOAD : BUS_STORE;
    assign mem_req.addr = addr[issue_idx];
    assign mem_req.data = data[issue_idx];

    assign fill.addr  = addr[fill_idx];
    assign fill.data  = data[fill_idx];
    assign fill.dirty = (kind[fill_idx] == MSHR_STORE);
    assign fill.id    = id[fill_idx];
    assign fill.kind  = kind[fill_idx];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                state[i] <= MS_IDLE;
                lq[i]    <= '0;
            end
            iq_head  <= '0;
            iq_tail  <= '0;
            iq_count <= '0;
            lq_push  <= '0;
            lq_rsp   <= '0;
            lq_fill  <= '0;
        end else begin
            if (issue_fire) begin
                iq_head <= iq_head + 1'b1;
                if (issue_load) begin
                    state[issue_idx] <= MS_WAIT;
                    lq[lq_push]      <= issue_idx;
                    lq_push          <= lq_push + 1'b1;
                end else begin
                    // write-back done once the store is on the bus
                    state[issue_idx] <= MS_IDLE;
                end
            end
            if (mem_rsp_valid) begin
                state[rsp_idx] <= MS_FILL;
                lq_rsp         <= lq_rsp + 1'b1;
            end
            if (fill_take) begin
                state[fill_idx] <= MS_IDLE;
                lq_fill         <= lq_fill + 1'b1;
            end
            // last, so a recycled fill entry ends up allocated
            if (alloc_valid) begin
                state[slot] <= MS_ISSUE;
                iq_tail     <= iq_tail + 1'b1;
            end
            iq_count <= iq_count + (PTR_W+1)'(alloc_valid) - (PTR_W+1)'(issue_fire);
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            iq[iq_tail] <= slot;
            kind[slot]  <= alloc.kind;
            addr[slot]  <= alloc.addr;
            data[slot]  <= alloc.data;
            id[slot]    <= alloc.id;
        end
        // store misses keep their own data as the merged word
        if (mem_rsp_valid && kind[rsp_idx] != MSHR_STORE) begin
            data[rsp_idx] <= mem_rsp.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache_req_intake.sv
`default_nettype none

module dcache_req_intake import dcache_types_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,

    // processor side
    input  dc_req_t req,
    input  logic    req_valid,
    output logic    req_ready,

    // toward the controller
    output dc_req_t cur,
    output logic    cur_valid,
    input  logic    cur_take
);

    logic load;

    // accept when empty or when the held request leaves this cycle
    assign req_ready = !cur_valid || cur_take;
    assign load      = req_valid && req_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cur_valid <= 1'b0;
        end else if (load) begin
            cur_valid <= 1'b1;
        end else if (cur_take) begin
            cur_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            cur <= req;
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache_top.sv
`default_nettype none

module dcache_top import dcache_types_pkg::*, mem_bus_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,

    // processor
    input  dc_req_t  req,
    input  logic     req_valid,
    output logic     req_ready,
    output dc_rsp_t  rsp,
    output logic     rsp_valid,

    // memory
    output mem_req_t mem_req,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    input  mem_rsp_t mem_rsp,
    input  logic     mem_rsp_valid
);

    dc_req_t     cur;
    logic        cur_valid;
    logic        cur_take;
    dc_addr_t    rd_addr;
    logic        rd_hit;
    dc_word_t    rd_data;
    dc_wr_t      wr;
    logic        wr_en;
    logic        evict_valid;
    logic        evict_dirty;
    dc_addr_t    evict_addr;
    dc_word_t    evict_data;
    dc_addr_t    search_addr;
    logic        search_hit;
    mshr_alloc_t alloc;
    logic        alloc_valid;
    logic        alloc_ready;
    fill_t       fill;
    logic        fill_valid;
    logic        fill_take;

    dcache_req_intake u_intake (
        .clock, .rst_n, .req, .req_valid, .req_ready, .cur, .cur_valid, .cur_take
    );

    dcache_controller u_ctrl (
        .clock, .rst_n, .cur, .cur_valid, .cur_take,
        .rd_addr, .rd_hit, .rd_data, .wr, .wr_en,
        .evict_valid, .evict_dirty, .evict_addr, .evict_data,
        .search_addr, .search_hit, .alloc, .alloc_valid, .alloc_ready,
        .fill, .fill_valid, .fill_take, .rsp, .rsp_valid
    );

    dcache_mem u_mem (
        .clock, .rst_n, .rd_addr, .rd_hit, .rd_data, .wr, .wr_en,
        .evict_valid, .evict_dirty, .evict_addr, .evict_data
    );

    dcache_mshr u_mshr (
        .clock, .rst_n, .alloc, .alloc_valid, .alloc_ready,
        .search_addr, .search_hit, .fill, .fill_valid, .fill_take,
        .mem_req, .mem_req_valid, .mem_req_ready, .mem_rsp, .mem_rsp_valid
    );

endmodule

`default_nettype wire

// File: logic/dcache_types_pkg.sv
`default_nettype none

`include "dcache_consts.svh"

package dcache_types_pkg;

    typedef logic [`DC_ADDR_BITS-1:0] dc_addr_t;
    typedef logic [`DC_WORD_BITS-1:0] dc_word_t;
    typedef logic [`DC_ID_BITS-1:0]   dc_id_t;

    typedef enum logic {
        DC_LOAD,
        DC_STORE
    } dc_op_e;

    // processor request, 80 bits
    typedef struct packed {
        dc_op_e   op;
        dc_addr_t addr;
        dc_word_t data;
        dc_id_t   id;
    } dc_req_t;

    // load response, 67 bits
    typedef struct packed {
        dc_id_t   id;
        dc_word_t data;
    } dc_rsp_t;

    // array write port command
    typedef struct packed {
        dc_addr_t addr;
        dc_word_t data;
        logic     dirty;
    } dc_wr_t;

endpackage

`default_nettype wire

// File: logic/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    import dcache_types_pkg::*;

    typedef enum logic {
        BUS_LOAD,
        BUS_STORE
    } bus_cmd_e;

    typedef enum logic [1:0] {
        MSHR_LOAD,
        MSHR_STORE,
        MSHR_EVICT
    } mshr_kind_e;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_ISSUE,
        MS_WAIT,
        MS_FILL
    } mshr_state_e;

    // 77 bits toward memory
    typedef struct packed {
        bus_cmd_e cmd;
        dc_addr_t addr;
        dc_word_t data;
    } mem_req_t;

    typedef struct packed {
        dc_word_t data;
    } mem_rsp_t;

    typedef struct packed {
        mshr_kind_e kind;
        dc_addr_t   addr;
        dc_word_t   data;
        dc_id_t     id;
    } mshr_alloc_t;

    // dirty is set for a merged store miss
    typedef struct packed {
        dc_addr_t   addr;
        dc_word_t   data;
        logic       dirty;
        dc_id_t     id;
        mshr_kind_e kind;
    } fill_t;

endpackage

`default_nettype wire

// File: tb/dcache_checker.sv
`default_nettype none

`include "dcache_consts.svh"

module dcache_checker import dcache_types_pkg::*, mem_bus_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  dc_req_t  req,
    input  logic     req_valid,
    input  logic     req_ready,
    input  dc_rsp_t  rsp,
    input  logic     rsp_valid,
    input  mem_req_t mem_req,
    input  logic     mem_req_valid,
    input  logic     mem_req_ready,
    output int       errors,
    output int       outstanding
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDS = 1 << `DC_ID_BITS;

    dc_word_t model [dc_addr_t];
    logic     touched [dc_addr_t];
    dc_word_t expect_data [IDS];
    logic     pending [IDS];
    logic     reset_checked;

    // a store held in the intake may be newer than a write-back on the bus
    logic     last_store;
    dc_addr_t last_addr;
    dc_word_t last_old;

    function automatic dc_word_t model_read(dc_addr_t a);
        return model.exists(a) ? model[a] : dc_word_t'(a);
    endfunction

    task automatic value_error(string name, dc_word_t got, dc_word_t exp);
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        errors = errors + 1;
    endtask

    initial begin
        errors        = 0;
        outstanding   = 0;
        reset_checked = 1'b0;
        last_store    = 1'b0;
        for (int i = 0; i < IDS; i++) begin
            pending[i] = 1'b0;
        end
    end

    always @(posedge clock) begin
        dc_word_t exp;
        if (rst_n && !reset_checked) begin
            reset_checked = 1'b1;
            if (req_ready !== 1'b1 || rsp_valid !== 1'b0 || mem_req_valid !== 1'b0) begin
                $display("outputs not in their reset state after reset at %0t", $time);
                errors = errors + 1;
            end
        end
        if (rst_n && rsp_valid) begin
            if (!pending[rsp.id]) begin
                $display("response at %0t with id %0d, no load outstanding", $time, rsp.id);
                errors = errors + 1;
            end else begin
                if (rsp.data !== expect_data[rsp.id]) begin
                    value_error("rsp.data", rsp.data, expect_data[rsp.id]);
                end
                pending[rsp.id] = 1'b0;
                outstanding = outstanding - 1;
            end
        end
        if (rst_n && req_valid && req_ready) begin
            touched[req.addr] = 1'b1;
            if (req.op == DC_LOAD) begin
                if (pending[req.id]) begin
                    $display("id %0d reused at %0t before its response", req.id, $time);
                    errors = errors + 1;
                end
                pending[req.id]     = 1'b1;
                expect_data[req.id] = model_read(req.addr);
                outstanding         = outstanding + 1;
                last_store          = 1'b0;
            end else begin
                last_store      = 1'b1;
                last_addr       = req.addr;
                last_old        = model_read(req.addr);
                model[req.addr] = req.data;
            end
        end
        if (rst_n && mem_req_valid && mem_req_ready) begin
            if (mem_req.cmd == BUS_LOAD) begin
                if (!touched.exists(mem_req.addr)) begin
                    $display("memory load at %0t for address %h never requested",
                             $time, mem_req.addr);
                    errors = errors + 1;
                end
            end else begin
                exp = model_read(mem_req.addr);
                if (mem_req.data !== exp && !(last_store && last_addr == mem_req.addr
                    && mem_req.data == last_old)) begin
                    value_error("mem_req.data", mem_req.data, exp);
                end
            end
        end
        // ready without a new transfer means the held store has left the intake
        if (rst_n && req_ready && !req_valid) begin
            last_store = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tb/dcache_properties.sv
`default_nettype none

module dcache_properties import dcache_types_pkg::*, mem_bus_pkg::*; (
    input logic     clock,
    input logic     rst_n,
    input dc_req_t  req,
    input logic     req_valid,
    input logic     req_ready,
    input dc_rsp_t  rsp,
    input logic     rsp_valid,
    input mem_req_t mem_req,
    input logic     mem_req_valid,
    input logic     mem_req_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    a_req_stable: assert property (@(posedge clock) disable iff (!rst_n)
        req_valid && !req_ready |=> $stable(req))
        else begin
            $error("req changed while stalled");
            fail_count++;
        end

    a_mem_req_stable: assert property (@(posedge clock) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else begin
            $error("mem_req dropped or changed while stalled");
            fail_count++;
        end

    a_rsp_known: assert property (@(posedge clock) disable iff (!rst_n)
        rsp_valid |-> !$isunknown(rsp))
        else begin
            $error("rsp has unknown bits");
            fail_count++;
        end

    // async reset clears outputs right away
    a_reset_state: assert property (@(posedge clock)
        !rst_n |-> req_ready && !rsp_valid && !mem_req_valid)
        else begin
            $error("outputs active during reset");
            fail_count++;
        end

endmodule

bind dcache_top dcache_properties u_props (.*);

`default_nettype wire

// File: tb/dcache_tb.sv
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb import dcache_types_pkg::*, mem_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQS    = 600;
    localparam int CYCLE_LIMIT = NUM_REQS * 40;
    localparam int POOL_SIZE   = 40;

    logic     clock;
    logic     rst_n;
    dc_req_t  req;
    logic     req_valid;
    logic     req_ready;
    dc_rsp_t  rsp;
    logic     rsp_valid;
    mem_req_t mem_req;
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_rsp_t mem_rsp;
    logic     mem_rsp_valid;

    int       checker_errors;
    int       loads_waiting;

    dc_addr_t pool [POOL_SIZE];
    dc_id_t   free_ids [$];
    dc_word_t mem_words [dc_addr_t];
    dc_word_t ld_data [$];
    int       ld_due [$];
    int       last_due;
    int       stall_left;
    int       sent;
    int       cycles;
    logic     timed_out;

    dcache_top i_dcache_top (.*);

    dcache_checker u_checker (
        .clock, .rst_n, .req, .req_valid, .req_ready, .rsp, .rsp_valid,
        .mem_req, .mem_req_valid, .mem_req_ready,
        .errors(checker_errors), .outstanding(loads_waiting)
    );

    function automatic dc_word_t mem_read(dc_addr_t a);
        return mem_words.exists(a) ? mem_words[a] : dc_word_t'(a);
    endfunction

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        rst_n         = 1'b1;
        req           = '0;
        req_valid     = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp       = '0;
        mem_rsp_valid = 1'b0;
        #5 rst_n = 1'b0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
    end

    // processor side with ids recycled by responses
    always @(posedge clock) begin
        dc_id_t id;
        if (rst_n) begin
            if (rsp_valid) begin
                free_ids.push_back(rsp.id);
            end
            if (req_valid && req_ready) begin
                sent = sent + 1;
                req_valid <= 1'b0;
            end
            if ((!req_valid || req_ready) && sent < NUM_REQS && free_ids.size() > 0
                && $urandom_range(3) != 0) begin
                id = free_ids.pop_front();
                req_valid <= 1'b1;
                if ($urandom_range(1) == 1) begin
                    req <= '{op: DC_STORE, addr: pool[$urandom_range(POOL_SIZE - 1)],
                             data: {$urandom(), $urandom()}, id: id};
                    // stores never answer
                    free_ids.push_back(id);
                end else begin
                    req <= '{op: DC_LOAD, addr: pool[$urandom_range(POOL_SIZE - 1)],
                             data: '0, id: id};
                end
            end
        end
    end

    // memory model with in-order load answers and random back-pressure
    always @(posedge clock) begin
        int due;
        if (rst_n) begin
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.cmd == BUS_STORE) begin
                    mem_words[mem_req.addr] = mem_req.data;
                end else begin
                    due = cycles + int'($urandom_range(12, 2));
                    if (due < last_due) begin
                        due = last_due;
                    end
                    last_due = due;
                    ld_data.push_back(mem_read(mem_req.addr));
                    ld_due.push_back(due);
                end
            end
            if (stall_left > 0) begin
                stall_left = stall_left - 1;
            end else if ($urandom_range(99) == 0) begin
                stall_left = int'($urandom_range(60, 20));
            end
            mem_req_ready <= (stall_left == 0) && ($urandom_range(9) < 7);
            mem_rsp_valid <= 1'b0;
            if (ld_due.size() > 0 && ld_due[0] <= cycles) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp.data  <= ld_data.pop_front();
                void'(ld_due.pop_front());
            end
        end
    end

    initial begin
        int idle;
        int total;
        void'($urandom(32'hd09ad8cc));
        cycles     = 0;
        sent       = 0;
        last_due   = 0;
        stall_left = 0;
        timed_out  = 1'b0;
        // pool spread over six indexes with many tags
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = {8'($urandom()), 4'(i % 6)};
        end
        for (int i = 0; i < (1 << `DC_ID_BITS); i++) begin
            free_ids.push_back(dc_id_t'(i));
        end
        idle = 0;
        while (idle < 30 && !timed_out) begin
            @(posedge clock);
            if (sent == NUM_REQS && !req_valid && free_ids.size() == (1 << `DC_ID_BITS)
                && !mem_req_valid && ld_due.size() == 0) begin
                idle = idle + 1;
            end else begin
                idle = 0;
            end
            if (cycles >= CYCLE_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout: run not finished after %0d cycles", cycles);
            end
        end
        if (loads_waiting != 0) begin
            $display("%0d loads never received a response", loads_waiting);
        end
        total = checker_errors + i_dcache_top.u_props.fail_count + int'(timed_out)
                + loads_waiting;
        $display("errors: checks %0d, assertions %0d, timeout %0d, unanswered %0d",
                 checker_errors, i_dcache_top.u_props.fail_count, int'(timed_out),
                 loads_waiting);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/dcache_types_pkg.sv
logic/mem_bus_pkg.sv
logic/dcache_req_intake.sv
logic/dcache_mem.sv
logic/dcache_controller.sv
logic/dcache_mshr.sv
logic/dcache_top.sv
tb/dcache_properties.sv
tb/dcache_checker.sv
tb/dcache_tb.sv
